// File: Bender.yml
package:
  name: systolic_mm

export_include_dirs:
  - .

sources:
  - files:
      - systolic_types_pkg.sv
      - matmul_ctrl_pkg.sv
      - processing_element.sv
      - operand_skew.sv
      - systolic_pe_matrix.sv
      - matmul_ctrl.sv
      - matmul_top.sv
  - target: test
    files:
      - matmul_tb.sv

// File: matmul_ctrl.sv
/*
 * Matrix multiply job controller
 * Accepts start, clears the mesh and pulses done when C is complete
 */

`timescale 1ns/1ns

`include "systolic_mm_settings.svh"

module matmul_ctrl import matmul_ctrl_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic in_valid,
  output logic clear,
  output logic busy,
  output logic done
);

  // the start cycle carries beat 0, so LOAD covers beats 1 to N-1
  localparam cnt_t LOAD_LAST = cnt_t'(`MAT_MUL_SIZE - 1);
  // last product lands at the end of cycle 3N-3, C is valid in 3N-2
  localparam cnt_t DONE_CNT  = cnt_t'(3 * `MAT_MUL_SIZE - 2);
  localparam cnt_t DONE_PRE  = cnt_t'(3 * `MAT_MUL_SIZE - 3);

  ctrl_state_t state;
  cnt_t        cnt;
  logic        accept;

  assign accept = start && (state == IDLE);
  assign clear  = accept;
  assign busy   = (state != IDLE) || start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= (state == DRAIN) && (cnt == DONE_PRE);
      case (state)
        IDLE: begin
          if (accept) begin
            state <= LOAD;
            cnt   <= cnt_t'(1);
          end
        end
        LOAD: begin
          cnt <= cnt + cnt_t'(1);
          if (cnt == LOAD_LAST) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (cnt == DONE_CNT) begin
            state <= IDLE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + cnt_t'(1);
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // the caller has to keep the beats coming for the whole load window
  a_load_beats: assert property (
    @(posedge clk) disable iff (!rst_n) (state == LOAD) |-> in_valid
  );

  // a stray beat outside a job would leak into the next sums
  a_no_idle_beat: assert property (
    @(posedge clk) disable iff (!rst_n) (state == IDLE && !start) |-> !in_valid
  );

  a_done_single: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !done
  );

endmodule

// File: matmul_ctrl_pkg.sv
/*
 * Matrix multiplier controller types
 * FSM state encoding and the job cycle counter
 */

`include "systolic_mm_settings.svh"

package matmul_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LOAD  = 2'd1,
    DRAIN = 2'd2
  } ctrl_state_t;

  // counts cycles since the accepted start, must reach 3N-2
  typedef logic [$clog2(3*`MAT_MUL_SIZE)-1:0] cnt_t;

endpackage

// File: matmul_tb.sv
/*
 * Testbench for the systolic matrix multiplier
 * Random jobs checked against a reference model, plus edge, busy and reset checks
 */

`timescale 1ns/1ns

`include "systolic_mm_settings.svh"

module matmul_tb import systolic_types_pkg::*;;

  localparam int N               = `MAT_MUL_SIZE;
  localparam int DONE_CYCLE      = 3 * N - 2;
  localparam int JOB_LIMIT       = 40;
  localparam int EXTRA_START_CYC = 5;
  localparam int NUM_JOBS        = 26;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * 30 + 100;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        in_valid;
  lane_vec_t   a_in;
  lane_vec_t   b_in;
  result_vec_t c_out;
  lane_vec_t   a_edge;
  lane_vec_t   b_edge;
  logic        busy;
  logic        done;

  elem_t  a_mat [N][N];
  elem_t  b_mat [N][N];
  integer seed;
  int     errors;
  int     checks;
  int     test_num;
  int     errs_start;

  matmul_top matmul_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .in_valid (in_valid),
    .a_in     (a_in),
    .b_in     (b_in),
    .c_out    (c_out),
    .a_edge   (a_edge),
    .b_edge   (b_edge),
    .busy     (busy),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  task automatic check_acc(input string name, input acc_t exp, input acc_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_elem(input string name, input elem_t exp, input elem_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  // C[i][j] is the dot product of row i of A and column j of B, wrapped to ACC_WIDTH
  function automatic acc_t model_c(input int i, input int j);
    longint sum;
    sum = 0;
    for (int k = 0; k < N; k++) begin
      sum += longint'(a_mat[i][k]) * longint'(b_mat[k][j]);
    end
    return acc_t'(sum % (longint'(1) << `ACC_WIDTH));
  endfunction

  task automatic fill_random();
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = elem_t'($random(seed));
        b_mat[r][c] = elem_t'($random(seed));
      end
    end
  endtask

  task automatic fill_const(input elem_t value);
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = value;
        b_mat[r][c] = value;
      end
    end
  endtask

  // every element differs, so a value on the wrong lane or cycle shows up
  task automatic fill_pattern();
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = elem_t'(16 * r + c + 1);
        b_mat[r][c] = elem_t'(8'h80 + 8 * r + c);
      end
    end
  endtask

  // outside the beats the lanes carry noise that the skew lines have to mask
  task automatic drive_beat(input int t, input bit extra_start);
    start    = (t == 0) || (extra_start && t == EXTRA_START_CYC);
    in_valid = (t < N);
    for (int l = 0; l < N; l++) begin
      a_in[l] = (t < N) ? a_mat[l][t] : elem_t'($random(seed));
      b_in[l] = (t < N) ? b_mat[t][l] : elem_t'($random(seed));
    end
  endtask

  // row i of A leaves the right edge 8 cycles after its skewed entry, B likewise
  task automatic check_edges(input int t);
    int    k;
    elem_t exp;
    for (int l = 0; l < N; l++) begin
      k = t - l - N;
      exp = (k >= 0 && k < N) ? a_mat[l][k] : '0;
      check_elem($sformatf("a_edge[%0d]", l), exp, a_edge[l]);
      exp = (k >= 0 && k < N) ? b_mat[k][l] : '0;
      check_elem($sformatf("b_edge[%0d]", l), exp, b_edge[l]);
    end
  endtask

  task automatic check_result();
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        check_acc($sformatf("c_out[%0d][%0d]", i, j), model_c(i, j), c_out[i*N+j]);
      end
    end
  endtask

  task automatic check_cleared();
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    for (int e = 0; e < N * N; e++) begin
      check_acc($sformatf("c_out[%0d][%0d]", e / N, e % N), '0, c_out[e]);
    end
  endtask

  // cycle t is sampled at its falling edge before the inputs for cycle t are driven
  task automatic run_job(input bit extra_start, input int abort_cycle);
    int t;
    bit seen_done;
    t = 0;
    seen_done = 1'b0;
    while (!seen_done && t <= JOB_LIMIT) begin
      @(negedge clk);
      if (t > 0) begin
        check_flag("busy", 1'b1, busy);
        check_flag("done", t == DONE_CYCLE, done);
        check_edges(t);
        seen_done = (done === 1'b1);
        if (seen_done) begin
          check_result();
        end
      end
      if (t == abort_cycle) begin
        return;
      end
      drive_beat(t, extra_start);
      t++;
    end
    if (!seen_done) begin
      errors++;
      $display("done did not arrive within %0d cycles of start", JOB_LIMIT);
    end
  endtask

  task automatic apply_reset();
    start    = 1'b0;
    in_valid = 1'b0;
    a_in     = '0;
    b_in     = '0;
    rst_n    = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (errors == errs_start) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, errors - errs_start);
    end
    errs_start = errors;
  endtask

  initial begin
    seed       = 40241;
    errors     = 0;
    checks     = 0;
    test_num   = 0;
    errs_start = 0;
    apply_reset();

    fill_random();
    run_job(1'b0, -1);
    repeat (3) @(negedge clk);
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    check_result();
    finish_test("single random job");

    // each job starts in the cycle after the previous done
    for (int n = 0; n < 20; n++) begin
      fill_random();
      run_job(1'b0, -1);
    end
    finish_test("twenty back-to-back jobs");

    fill_random();
    run_job(1'b1, -1);
    repeat (2) @(negedge clk);
    check_result();
    finish_test("start while busy ignored");

    fill_const(8'hFF);
    run_job(1'b0, -1);
    finish_test("all-0xFF operands");

    fill_pattern();
    run_job(1'b0, -1);
    finish_test("edge output timing");

    fill_random();
    run_job(1'b0, 6);
    apply_reset();
    check_cleared();
    fill_random();
    run_job(1'b0, -1);
    finish_test("reset during a job");

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: matmul_top.sv
/*
 * Systolic matrix multiplier top level
 * Skew lines for A and B feed the PE mesh under the job controller
 */

`timescale 1ns/1ns

`include "systolic_mm_settings.svh"

module matmul_top import systolic_types_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        in_valid,
  input  lane_vec_t   a_in,
  input  lane_vec_t   b_in,
  output result_vec_t c_out,
  output lane_vec_t   a_edge,
  output lane_vec_t   b_edge,
  output logic        busy,
  output logic        done
);

  lane_vec_t a_skewed;
  lane_vec_t b_skewed;
  logic      clear;

  // rows of A, lane i is A[i][k]
  operand_skew a_skew_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .lanes_in  (a_in),
    .lanes_out (a_skewed)
  );

  // columns of B, lane j is B[k][j]
  operand_skew b_skew_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .lanes_in  (b_in),
    .lanes_out (b_skewed)
  );

  systolic_pe_matrix mesh_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (clear),
    .a_left (a_skewed),
    .b_top  (b_skewed),
    .c_out  (c_out),
    .a_edge (a_edge),
    .b_edge (b_edge)
  );

  matmul_ctrl ctrl_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .in_valid (in_valid),
    .clear    (clear),
    .busy     (busy),
    .done     (done)
  );

endmodule

// File: operand_skew.sv
/*
 * Operand skew line
 * Delays lane i by i cycles and feeds zeros while no beat is valid
 */

`timescale 1ns/1ns

`include "systolic_mm_settings.svh"

module operand_skew import systolic_types_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  lane_vec_t lanes_in,
  output lane_vec_t lanes_out
);

  lane_vec_t masked;

  assign masked = in_valid ? lanes_in : '0;

  // lane 0 enters the mesh in the same cycle as the beat
  assign lanes_out[0] = masked[0];

  for (genvar i = 1; i < `MAT_MUL_SIZE; i++) begin : g_lane
    elem_t dly [i];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int s = 0; s < i; s++) begin
          dly[s] <= '0;
        end
      end else begin
        dly[0] <= masked[i];
        for (int s = 1; s < i; s++) begin
          dly[s] <= dly[s-1];
        end
      end
    end

    assign lanes_out[i] = dly[i-1];
  end

endmodule

// File: processing_element.sv
/*
 * Processing element
 * Multiply-accumulate cell that forwards A to the right and B downwards
 */

`timescale 1ns/1ns

`include "systolic_mm_settings.svh"

module processing_element import systolic_types_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clear,
  input  elem_t in_a,
  input  elem_t in_b,
  output elem_t out_a,
  output elem_t out_b,
  output acc_t  out_c
);

  acc_t product;

  // zero-extend before multiplying so the product fits the accumulator
  assign product = acc_t'(in_a) * acc_t'(in_b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // clear starts a new sum with the first product of the job
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_c <= '0;
    end else if (clear) begin
      out_c <= product;
    end else begin
      out_c <= out_c + product;
    end
  end

endmodule

// File: systolic_mm.f
+incdir+.
systolic_types_pkg.sv
matmul_ctrl_pkg.sv
processing_element.sv
operand_skew.sv
systolic_pe_matrix.sv
matmul_ctrl.sv
matmul_top.sv
matmul_tb.sv

// File: systolic_mm_settings.svh
/*
 * Systolic matrix multiplier settings
 * Element width, accumulator width and mesh dimension shared by all blocks
 */

`ifndef SYSTOLIC_MM_SETTINGS_SVH
`define SYSTOLIC_MM_SETTINGS_SVH

// operand width of one matrix element
`define DWIDTH 8

// accumulators wrap modulo 2**ACC_WIDTH
`define ACC_WIDTH 20

// the mesh is MAT_MUL_SIZE by MAT_MUL_SIZE processing elements
`define MAT_MUL_SIZE 8

`endif

// File: systolic_pe_matrix.sv
/*
 * Systolic PE mesh
 * N by N grid of MAC cells, A flows right and B flows down
 */

`timescale 1ns/1ns

`include "systolic_mm_settings.svh"

module systolic_pe_matrix import systolic_types_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clear,
  input  lane_vec_t   a_left,
  input  lane_vec_t   b_top,
  output result_vec_t c_out,
  output lane_vec_t   a_edge,
  output lane_vec_t   b_edge
);

  // a_link[i][j] enters PE(i,j) from the left, column N is the right edge
  elem_t a_link [`MAT_MUL_SIZE][`MAT_MUL_SIZE+1];

  // b_link[i][j] enters PE(i,j) from above, row N is the bottom edge
  elem_t b_link [`MAT_MUL_SIZE+1][`MAT_MUL_SIZE];

  for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_left
    assign a_link[i][0] = a_left[i];
    assign a_edge[i]    = a_link[i][`MAT_MUL_SIZE];
  end

  for (genvar j = 0; j < `MAT_MUL_SIZE; j++) begin : g_top
    assign b_link[0][j] = b_top[j];
    assign b_edge[j]    = b_link[`MAT_MUL_SIZE][j];
  end

  for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MAT_MUL_SIZE; j++) begin : g_col
      processing_element pe_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (clear),
        .in_a  (a_link[i][j]),
        .in_b  (b_link[i][j]),
        .out_a (a_link[i][j+1]),
        .out_b (b_link[i+1][j]),
        .out_c (c_out[i*`MAT_MUL_SIZE+j])
      );
    end
  end

endmodule

// File: systolic_types_pkg.sv
/*
 * Systolic datapath types
 * Elements, accumulators and the lane vectors that cross the mesh boundary
 */

`include "systolic_mm_settings.svh"

package systolic_types_pkg;

  // one unsigned matrix element
  typedef logic [`DWIDTH-1:0] elem_t;

  // one unsigned accumulator of the result matrix
  typedef logic [`ACC_WIDTH-1:0] acc_t;

  // one element per row or column lane, lane 0 in the low bits
  typedef elem_t [`MAT_MUL_SIZE-1:0] lane_vec_t;

  // whole result matrix, element (i,j) sits at index i*N+j
  typedef acc_t [`MAT_MUL_SIZE*`MAT_MUL_SIZE-1:0] result_vec_t;

endpackage
